/* program_input.txt */
# I <instruction word, hex>                      program words in address order
# W <register index, hex> <value, hex>           write-backs in program order
I 20010005  # addi r1, r0, 5
I 2002fffd  # addi r2, r0, -3
I 2003000c  # addi r3, r0, 12
I 00232020  # add  r4, r1, r3
I 00612822  # sub  r5, r3, r1
I 00233024  # and  r6, r1, r3
I 00233825  # or   r7, r1, r3
I 0041402a  # slt  r8, r2, r1  (signed, -3 < 5)
I 00215020  # add  r10, r1, r1
I 01415820  # add  r11, r10, r1  (distance 1)
I 01436022  # sub  r12, r10, r3  (distance 2)
I 01406825  # or   r13, r10, r0  (distance 3)
I 200e0040  # addi r14, r0, 64  (data base)
I adcb0004  # sw   r11, 4(r14)
I 200f1234  # addi r15, r0, 0x1234
I adcf0008  # sw   r15, 8(r14)  (store data from previous instr)
I 8dd00004  # lw   r16, 4(r14)
I 8dd10008  # lw   r17, 8(r14)
I 02219020  # add  r18, r17, r1  (load-use)
I 20000007  # addi r0, r0, 7  (no write-back)
I 00210020  # add  r0, r1, r1  (no write-back)
I 00000000  # nop
I 00019820  # add  r19, r0, r1
W 01 00000005
W 02 fffffffd
W 03 0000000c
W 04 00000011
W 05 00000007
W 06 00000004
W 07 0000000d
W 08 00000001
W 0a 0000000a
W 0b 0000000f
W 0c fffffffe
W 0d 0000000a
W 0e 00000040
W 0f 00001234
W 10 0000000f
W 11 00001234
W 12 00001239
W 13 00000005

/* sources.f */
+incdir+.
mips_pkg.sv
fetch_decode.sv
reg_file.sv
execute.sv
mem_writeback.sv
mips_pipe.sv
tb_mips_pipe.sv

/* tb_mips_pipe.sv */
`include "mips_params.svh"

module tb_mips_pipe;

    localparam int WB_TIMEOUT = 40; // cycles allowed per expected write-back
    localparam int QUIET      = 20; // idle cycles checked after the last one

    logic                clk;
    logic                rstn;
    logic                run;
    logic                imem_we;
    logic [7:0]          imem_addr;
    mips_pkg::word_t     imem_wdata;
    logic                wb_en;
    mips_pkg::reg_addr_t wb_reg;
    mips_pkg::word_t     wb_data;

    mips_pkg::word_t     prog [$];     // program words, in address order
    mips_pkg::reg_addr_t exp_reg [$];  // expected write-backs, in program order
    mips_pkg::word_t     exp_data [$];

    mips_pipe dut_i (
        .clk, .rstn, .run,
        .imem_we, .imem_addr, .imem_wdata,
        .wb_en, .wb_reg, .wb_data
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_on_error();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            stop_on_error();
        end
    endtask

    // I lines hold program words, W lines a register index and its value
    task automatic read_program();
        int          fd;
        int          ch;
        int          code;
        logic [31:0] word;
        logic [31:0] reg_idx;
        logic [31:0] value;
        fd = $fopen("program_input.txt", "r");
        if (fd == 0) begin
            $display("could not open program_input.txt");
            stop_on_error();
        end
        ch = $fgetc(fd);
        while (ch != -1) begin
            if (ch == "I") begin
                code = $fscanf(fd, "%h", word);
                if (code != 1) begin
                    $display("bad program line after word %0d", prog.size());
                    stop_on_error();
                end
                prog.push_back(word);
            end else if (ch == "W") begin
                code = $fscanf(fd, "%h %h", reg_idx, value);
                if (code != 2) begin
                    $display("bad expectation line after entry %0d", exp_reg.size());
                    stop_on_error();
                end
                exp_reg.push_back(reg_idx[4:0]);
                exp_data.push_back(value);
            end
            while (ch != -1 && ch != "\n") // rest of line is comment
                ch = $fgetc(fd);
            ch = $fgetc(fd);
        end
        $fclose(fd);
        if (prog.size() == 0 || prog.size() > `TEXT_WORDS || exp_reg.size() == 0) begin
            $display("program file holds %0d words and %0d expectations, not usable",
                     prog.size(), exp_reg.size());
            stop_on_error();
        end
    endtask

    // next negedge with wb_en high, bounded
    task automatic wait_write_back(input int idx);
        int n;
        n = 0;
        @(negedge clk);
        while (!wb_en && n < WB_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!wb_en) begin
            $display("write-back %0d (r%0d = %h) never arrived within %0d cycles",
                     idx, exp_reg[idx], exp_data[idx], WB_TIMEOUT);
            stop_on_error();
        end
    endtask

    initial begin
        int k;
        rstn       = 1'b0;
        run        = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        read_program();
        repeat (2) @(posedge clk);
        rstn <= 1'b1;

        // load with run low, pipeline must stay silent
        for (k = 0; k < prog.size(); k++) begin
            @(posedge clk);
            imem_we    <= 1'b1;
            imem_addr  <= k[7:0];
            imem_wdata <= prog[k];
            @(negedge clk);
            check_value("wb_en", wb_en, 1'b0);
        end
        @(posedge clk);
        imem_we <= 1'b0;
        @(posedge clk);
        run <= 1'b1; // fetch starts at TEXT_START

        for (k = 0; k < exp_reg.size(); k++) begin
            wait_write_back(k);
            check_value("wb_reg", wb_reg, exp_reg[k]);
            check_value("wb_data", wb_data, exp_data[k]);
        end

        // nothing more may retire, r0 targets and no-ops included
        repeat (QUIET) begin
            @(negedge clk);
            if (wb_en) begin
                $display("unexpected write-back to r%0d after the last expected one", wb_reg);
                stop_on_error();
            end
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

/* mips_pipe.sv */
module mips_pipe (
    input  logic                clk,
    input  logic                rstn,
    input  logic                run,
    input  logic                imem_we,
    input  logic [7:0]          imem_addr,
    input  mips_pkg::word_t     imem_wdata,
    output logic                wb_en,
    output mips_pkg::reg_addr_t wb_reg,
    output mips_pkg::word_t     wb_data
);

    // register file read port
    mips_pkg::reg_addr_t rd_addr_1, rd_addr_2;
    mips_pkg::word_t     rd_data_1, rd_data_2;

    // ID/EX
    mips_pkg::reg_addr_t ex_rs, ex_rt, ex_dst;
    logic                ex_reg_write, ex_mem_read, ex_mem_write, ex_alu_src;
    mips_pkg::alu_op_t   ex_alu_op;
    mips_pkg::word_t     ex_rd_data_1, ex_rd_data_2, ex_imm;

    // EX/MEM
    mips_pkg::word_t     mem_result, mem_store_data;
    mips_pkg::reg_addr_t mem_dst;
    logic                mem_reg_write, mem_read, mem_write;

    fetch_decode fetch_decode_i (
        .clk, .rstn, .run,
        .imem_we, .imem_addr, .imem_wdata,
        .rd_data_1, .rd_data_2,
        .rd_addr_1, .rd_addr_2,
        .ex_rs, .ex_rt, .ex_dst,
        .ex_reg_write, .ex_mem_read, .ex_mem_write,
        .ex_alu_src, .ex_alu_op,
        .ex_rd_data_1, .ex_rd_data_2, .ex_imm
    );

    reg_file reg_file_i (
        .clk, .rstn,
        .rd_addr_1, .rd_addr_2,
        .wb_en, .wb_reg, .wb_data, // write port from MEM/WB
        .rd_data_1, .rd_data_2
    );

    execute execute_i (
        .clk, .rstn,
        .ex_rs, .ex_rt, .ex_dst,
        .ex_reg_write, .ex_mem_read, .ex_mem_write,
        .ex_alu_src, .ex_alu_op,
        .ex_rd_data_1, .ex_rd_data_2, .ex_imm,
        .wb_en, .wb_reg, .wb_data, // MEM/WB forwarding
        .mem_result, .mem_store_data, .mem_dst,
        .mem_reg_write, .mem_read, .mem_write
    );

    mem_writeback mem_writeback_i (
        .clk, .rstn,
        .mem_result, .mem_store_data, .mem_dst,
        .mem_reg_write, .mem_read, .mem_write,
        .wb_en, .wb_reg, .wb_data
    );

endmodule

/* mem_writeback.sv */
`include "mips_params.svh"

module mem_writeback (
    input  logic                clk,
    input  logic                rstn,
    input  mips_pkg::word_t     mem_result,
    input  mips_pkg::word_t     mem_store_data,
    input  mips_pkg::reg_addr_t mem_dst,
    input  logic                mem_reg_write,
    input  logic                mem_read,
    input  logic                mem_write,
    output logic                wb_en,
    output mips_pkg::reg_addr_t wb_reg,
    output mips_pkg::word_t     wb_data
);

    localparam int DATA_AW = $clog2(`DATA_WORDS);

    mips_pkg::word_t    dmem [`DATA_WORDS];
    mips_pkg::word_t    dm_off;     // byte offset from data base
    logic [DATA_AW-1:0] dm_idx;
    mips_pkg::word_t    dm_rdata;
    logic               wb_load;    // loaded word selected at write-back
    mips_pkg::word_t    wb_load_q;
    mips_pkg::word_t    wb_alu_q;

    assign dm_off   = mem_result - `DATA_START;
    assign dm_idx   = dm_off[DATA_AW+1:2];
    assign dm_rdata = dmem[dm_idx]; // async read

    always_ff @(posedge clk) begin
        if (mem_write)
            dmem[dm_idx] <= mem_store_data;
    end

    // MEM/WB register
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wb_en     <= 1'b0;
            wb_load   <= 1'b0;
            wb_reg    <= '0;
            wb_load_q <= '0;
            wb_alu_q  <= '0;
        end else begin
            wb_en     <= mem_reg_write;
            wb_load   <= mem_read;
            wb_reg    <= mem_dst;
            wb_load_q <= dm_rdata;
            wb_alu_q  <= mem_result;
        end
    end

    assign wb_data = wb_load ? wb_load_q : wb_alu_q; // lw vs alu result

endmodule

/* execute.sv */
module execute (
    input  logic                clk,
    input  logic                rstn,
    input  mips_pkg::reg_addr_t ex_rs,
    input  mips_pkg::reg_addr_t ex_rt,
    input  mips_pkg::reg_addr_t ex_dst,
    input  logic                ex_reg_write,
    input  logic                ex_mem_read,
    input  logic                ex_mem_write,
    input  logic                ex_alu_src,
    input  mips_pkg::alu_op_t   ex_alu_op,
    input  mips_pkg::word_t     ex_rd_data_1,
    input  mips_pkg::word_t     ex_rd_data_2,
    input  mips_pkg::word_t     ex_imm,
    input  logic                wb_en,
    input  mips_pkg::reg_addr_t wb_reg,
    input  mips_pkg::word_t     wb_data,
    output mips_pkg::word_t     mem_result,
    output mips_pkg::word_t     mem_store_data,
    output mips_pkg::reg_addr_t mem_dst,
    output logic                mem_reg_write,
    output logic                mem_read,
    output logic                mem_write
);

    mips_pkg::fwd_sel_t fwd_a;
    mips_pkg::fwd_sel_t fwd_b;
    mips_pkg::word_t    rs_val;   // forwarded rs
    mips_pkg::word_t    rt_val;   // forwarded rt and store data
    mips_pkg::word_t    alu_b;
    mips_pkg::word_t    alu_y;

    // newest producer wins so EX/MEM beats MEM/WB
    function automatic mips_pkg::fwd_sel_t pick_src(input mips_pkg::reg_addr_t src);
        if (mem_reg_write && (mem_dst == src))
            return mips_pkg::FWD_EXMEM;
        else if (wb_en && (wb_reg == src))
            return mips_pkg::FWD_MEMWB;
        else
            return mips_pkg::FWD_REG;
    endfunction

    function automatic mips_pkg::word_t fwd_mux(input mips_pkg::fwd_sel_t sel,
                                                input mips_pkg::word_t    reg_val);
        case (sel)
            mips_pkg::FWD_EXMEM: return mem_result;
            mips_pkg::FWD_MEMWB: return wb_data;
            default:             return reg_val;
        endcase
    endfunction

    // r0 never leaves ID with its write enable set
    always_comb begin
        fwd_a  = pick_src(ex_rs);
        fwd_b  = pick_src(ex_rt);
        rs_val = fwd_mux(fwd_a, ex_rd_data_1);
        rt_val = fwd_mux(fwd_b, ex_rd_data_2);
    end

    assign alu_b = ex_alu_src ? ex_imm : rt_val; // immediate for addi/lw/sw

    always_comb begin
        case (ex_alu_op)
            mips_pkg::ALU_ADD: alu_y = rs_val + alu_b;
            mips_pkg::ALU_SUB: alu_y = rs_val - alu_b;
            mips_pkg::ALU_AND: alu_y = rs_val & alu_b;
            mips_pkg::ALU_OR:  alu_y = rs_val | alu_b;
            mips_pkg::ALU_SLT: alu_y = {31'd0, $signed(rs_val) < $signed(alu_b)};
            default:           alu_y = '0;
        endcase
    end

    // EX/MEM register
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mem_reg_write  <= 1'b0;
            mem_read       <= 1'b0;
            mem_write      <= 1'b0;
            mem_result     <= '0;
            mem_store_data <= '0;
            mem_dst        <= '0;
        end else begin
            mem_reg_write  <= ex_reg_write;
            mem_read       <= ex_mem_read;
            mem_write      <= ex_mem_write;
            mem_result     <= alu_y;
            mem_store_data <= rt_val;
            mem_dst        <= ex_dst;
        end
    end

endmodule

/* reg_file.sv */
module reg_file (
    input  logic                clk,
    input  logic                rstn,
    input  mips_pkg::reg_addr_t rd_addr_1,
    input  mips_pkg::reg_addr_t rd_addr_2,
    input  logic                wb_en,
    input  mips_pkg::reg_addr_t wb_reg,
    input  mips_pkg::word_t     wb_data,
    output mips_pkg::word_t     rd_data_1,
    output mips_pkg::word_t     rd_data_2
);

    mips_pkg::word_t regs [32];

    // r0 reads zero and a same-cycle write passes straight through
    function automatic mips_pkg::word_t read_port(input mips_pkg::reg_addr_t addr);
        if (addr == '0)
            return '0;
        else if (wb_en && (wb_reg == addr))
            return wb_data; // bypass
        else
            return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wb_en && (wb_reg != '0)) begin
            regs[wb_reg] <= wb_data;
        end
    end

    always_comb begin
        rd_data_1 = read_port(rd_addr_1);
        rd_data_2 = read_port(rd_addr_2);
    end

endmodule

/* fetch_decode.sv */
`include "mips_params.svh"

module fetch_decode (
    input  logic                clk,
    input  logic                rstn,
    input  logic                run,
    input  logic                imem_we,
    input  logic [7:0]          imem_addr,
    input  mips_pkg::word_t     imem_wdata,
    input  mips_pkg::word_t     rd_data_1,
    input  mips_pkg::word_t     rd_data_2,
    output mips_pkg::reg_addr_t rd_addr_1,
    output mips_pkg::reg_addr_t rd_addr_2,
    output mips_pkg::reg_addr_t ex_rs,
    output mips_pkg::reg_addr_t ex_rt,
    output mips_pkg::reg_addr_t ex_dst,
    output logic                ex_reg_write,
    output logic                ex_mem_read,
    output logic                ex_mem_write,
    output logic                ex_alu_src,
    output mips_pkg::alu_op_t   ex_alu_op,
    output mips_pkg::word_t     ex_rd_data_1,
    output mips_pkg::word_t     ex_rd_data_2,
    output mips_pkg::word_t     ex_imm
);

    localparam int TEXT_AW = $clog2(`TEXT_WORDS);

    mips_pkg::word_t     imem [`TEXT_WORDS]; // program store filled through the load port
    mips_pkg::word_t     pc;
    mips_pkg::word_t     pc_off;              // byte offset into text segment
    logic [TEXT_AW-1:0]  fetch_idx;
    mips_pkg::word_t     if_id_instr;

    logic [5:0]          opcode;
    logic [5:0]          funct;
    mips_pkg::reg_addr_t id_rd;
    mips_pkg::reg_addr_t id_dst;
    mips_pkg::word_t     id_imm;
    logic                dec_reg_dst;
    logic                dec_reg_write;
    logic                dec_mem_read;
    logic                dec_mem_write;
    logic                dec_alu_src;
    mips_pkg::alu_op_t   dec_alu_op;
    logic                id_reg_write;        // after the r0 squash
    logic                stall;

    // word-indexed load port
    always_ff @(posedge clk) begin
        if (imem_we)
            imem[imem_addr] <= imem_wdata;
    end

    assign pc_off    = pc - `TEXT_START;
    assign fetch_idx = pc_off[TEXT_AW+1:2]; // drop byte bits

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc          <= `TEXT_START;
            if_id_instr <= '0;
        end else if (!run) begin
            pc          <= `TEXT_START;      // park until program is loaded
            if_id_instr <= '0;               // feed no-ops
        end else if (!stall) begin
            pc          <= pc + 32'd4;
            if_id_instr <= imem[fetch_idx];
        end
    end

    // instruction fields
    assign opcode    = if_id_instr[31:26];
    assign funct     = if_id_instr[5:0];
    assign rd_addr_1 = if_id_instr[25:21]; // rs
    assign rd_addr_2 = if_id_instr[20:16]; // rt
    assign id_rd     = if_id_instr[15:11];
    assign id_imm    = {{16{if_id_instr[15]}}, if_id_instr[15:0]};

    // main decoder that leaves unknown words as no-ops
    always_comb begin
        dec_reg_dst   = 1'b0;
        dec_reg_write = 1'b0;
        dec_mem_read  = 1'b0;
        dec_mem_write = 1'b0;
        dec_alu_src   = 1'b0;
        dec_alu_op    = mips_pkg::ALU_ADD;
        case (opcode)
            `OP_RTYPE: begin
                dec_reg_dst   = 1'b1;
                dec_reg_write = 1'b1;
                case (funct)
                    `FN_ADD: dec_alu_op = mips_pkg::ALU_ADD;
                    `FN_SUB: dec_alu_op = mips_pkg::ALU_SUB;
                    `FN_AND: dec_alu_op = mips_pkg::ALU_AND;
                    `FN_OR:  dec_alu_op = mips_pkg::ALU_OR;
                    `FN_SLT: dec_alu_op = mips_pkg::ALU_SLT;
                    default: dec_reg_write = 1'b0; // incl. all-zero word
                endcase
            end
            `OP_ADDI: begin
                dec_reg_write = 1'b1;
                dec_alu_src   = 1'b1;
            end
            `OP_LW: begin
                dec_reg_write = 1'b1;
                dec_mem_read  = 1'b1;
                dec_alu_src   = 1'b1;
            end
            `OP_SW: begin
                dec_mem_write = 1'b1;
                dec_alu_src   = 1'b1;
            end
            default: ;
        endcase
    end

    assign id_dst       = dec_reg_dst ? id_rd : rd_addr_2;
    assign id_reg_write = dec_reg_write && (id_dst != '0); // writes to r0 are dropped

    // load in EX whose result the instruction in ID needs
    assign stall = ex_mem_read && (ex_dst != '0) &&
                   ((ex_dst == rd_addr_1) || (ex_dst == rd_addr_2));

    // ID/EX register
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_alu_src   <= 1'b0;
            ex_alu_op    <= mips_pkg::ALU_ADD;
            ex_rs        <= '0;
            ex_rt        <= '0;
            ex_dst       <= '0;
            ex_rd_data_1 <= '0;
            ex_rd_data_2 <= '0;
            ex_imm       <= '0;
        end else begin
            ex_reg_write <= id_reg_write && !stall; // bubble while stalled
            ex_mem_read  <= dec_mem_read && !stall;
            ex_mem_write <= dec_mem_write && !stall;
            ex_alu_src   <= dec_alu_src;
            ex_alu_op    <= dec_alu_op;
            ex_rs        <= rd_addr_1;
            ex_rt        <= rd_addr_2;
            ex_dst       <= id_dst;
            ex_rd_data_1 <= rd_data_1;
            ex_rd_data_2 <= rd_data_2;
            ex_imm       <= id_imm;
        end
    end

endmodule

/* mips_pkg.sv */
package mips_pkg;

    // data word, also used for byte addresses
    typedef logic [31:0] word_t;

    // register index, r0 is hardwired zero
    typedef logic [4:0] reg_addr_t;

    // alu operations decoded in ID
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0, // add, addi, lw/sw address
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4  // signed compare
    } alu_op_t;

    // operand source picked by the forwarding logic in EX
    typedef enum logic [1:0] {
        FWD_REG   = 2'd0, // value read in ID, carried in ID/EX
        FWD_EXMEM = 2'd1, // alu result sitting in EX/MEM
        FWD_MEMWB = 2'd2  // write-back data out of MEM/WB
    } fwd_sel_t;

endpackage

/* mips_params.svh */
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// memory map
`define TEXT_START 32'h0040_0000 // first instruction byte address
`define TEXT_WORDS 256           // instruction memory depth in words
`define DATA_START 32'h1000_8000 // first data byte address
`define DATA_WORDS 256           // data memory depth in words

// opcodes, instr[31:26]
`define OP_RTYPE 6'h00
`define OP_ADDI  6'h08
`define OP_LW    6'h23
`define OP_SW    6'h2b

// r-type function codes, instr[5:0]
`define FN_ADD 6'h20
`define FN_SUB 6'h22
`define FN_AND 6'h24
`define FN_OR  6'h25
`define FN_SLT 6'h2a

`endif
